//--- design/rsa256_pkg.sv
package rsa256_pkg;

    typedef logic [255:0] rsa_word_t;
    typedef logic [4:0]   avm_addr_t;
    typedef logic [31:0]  avm_data_t;
    typedef logic [6:0]   byte_cnt_t;

    // peripheral register map, byte addresses on the Avalon side.
    localparam avm_addr_t RX_BASE     = 5'd0;
    localparam avm_addr_t TX_BASE     = 5'd4;
    localparam avm_addr_t STATUS_BASE = 5'd8;
    localparam int        RX_OK_BIT   = 7;
    localparam int        TX_OK_BIT   = 6;

    localparam byte_cnt_t KEY_N_BYTES = 7'd32;
    localparam byte_cnt_t KEY_D_BYTES = 7'd32;
    localparam byte_cnt_t BLOCK_BYTES = 7'd32;
    localparam byte_cnt_t OUT_BYTES   = 7'd31;

    typedef struct packed {
        rsa_word_t base;
        rsa_word_t exp;
        rsa_word_t modulus;
    } rsa_job_t;

    typedef enum logic [2:0] {
        QUERY_RX,
        GET_KEY,
        GET_DATA,
        WAIT_CALC,
        QUERY_TX,
        SEND_DATA
    } wrap_state_t;

endpackage

//--- design/rsa256_mont.sv
`timescale 1ns/1ns

module rsa256_mont
    import rsa256_pkg::*;
(
    input  logic      avm_clk,
    input  logic      avm_rst,
    input  logic      start,
    input  rsa_word_t a,
    input  rsa_word_t b,
    input  rsa_word_t n,
    output rsa_word_t result,
    output logic      finished
);

    rsa_word_t    a_r;
    rsa_word_t    b_r;
    rsa_word_t    n_r;
    logic [257:0] acc;
    logic [257:0] sum_a;
    logic [257:0] sum_n;
    logic [257:0] acc_sub;
    logic [8:0]   step;
    logic         busy;

    // adding n when the sum is odd makes the halving exact modulo n.
    always_comb begin
        sum_a = acc + (b_r[0] ? {2'b00, a_r} : 258'd0);
        sum_n = sum_a + (sum_a[0] ? {2'b00, n_r} : 258'd0);
    end

    assign acc_sub = acc - {2'b00, n_r};

    always_ff @(posedge avm_clk or posedge avm_rst) begin
        if (avm_rst) begin
            busy     <= 1'b0;
            step     <= '0;
            finished <= 1'b0;
        end else begin
            finished <= 1'b0;
            if (start) begin
                busy <= 1'b1;
                step <= '0;
            end else if (busy) begin
                if (step == 9'd256) begin
                    busy     <= 1'b0;
                    finished <= 1'b1;
                end else begin
                    step <= step + 9'd1;
                end
            end
        end
    end

    // the accumulator stays below 2n, so one subtraction is enough at the end.
    always_ff @(posedge avm_clk) begin
        if (start) begin
            a_r <= a;
            b_r <= b;
            n_r <= n;
            acc <= '0;
        end else if (busy) begin
            if (step == 9'd256) begin
                result <= (acc >= {2'b00, n_r}) ? acc_sub[255:0] : acc[255:0];
            end else begin
                acc <= {1'b0, sum_n[257:1]};
                b_r <= {1'b0, b_r[255:1]};
            end
        end
    end

endmodule

//--- design/rsa256_mod_prod.sv
`timescale 1ns/1ns

module rsa256_mod_prod
    import rsa256_pkg::*;
(
    input  logic      avm_clk,
    input  logic      avm_rst,
    input  logic      start,
    input  rsa_word_t a,
    input  rsa_word_t n,
    output rsa_word_t result,
    output logic      finished
);

    rsa_word_t    acc;
    rsa_word_t    n_r;
    logic [256:0] dbl;
    logic [256:0] dbl_sub;
    logic [8:0]   step;
    logic         busy;

    // a is below n, so after each doubling one subtraction keeps acc reduced.
    assign dbl     = {acc, 1'b0};
    assign dbl_sub = dbl - {1'b0, n_r};

    always_ff @(posedge avm_clk or posedge avm_rst) begin
        if (avm_rst) begin
            busy     <= 1'b0;
            step     <= '0;
            finished <= 1'b0;
        end else begin
            finished <= 1'b0;
            if (start) begin
                busy <= 1'b1;
                step <= '0;
            end else if (busy) begin
                if (step == 9'd256) begin
                    busy     <= 1'b0;
                    finished <= 1'b1;
                end else begin
                    step <= step + 9'd1;
                end
            end
        end
    end

    always_ff @(posedge avm_clk) begin
        if (start) begin
            acc <= a;
            n_r <= n;
        end else if (busy) begin
            if (step == 9'd256) begin
                result <= acc;
            end else begin
                acc <= (dbl >= {1'b0, n_r}) ? dbl_sub[255:0] : dbl[255:0];
            end
        end
    end

endmodule

//--- design/rsa256_core.sv
`timescale 1ns/1ns

module rsa256_core
    import rsa256_pkg::*;
(
    input  logic      avm_clk,
    input  logic      avm_rst,
    input  logic      start,
    input  rsa_job_t  job,
    output rsa_word_t result,
    output logic      finished
);

    typedef enum logic [1:0] {
        CORE_IDLE,
        CORE_PREP,
        CORE_LOOP,
        CORE_DONE
    } core_state_t;

    core_state_t state;
    logic        prep_start;
    logic        mont_start;
    logic        prep_done;
    logic        mul_done;
    logic        sq_done;
    rsa_word_t   prep_res;
    rsa_word_t   mul_res;
    rsa_word_t   sq_res;
    rsa_word_t   m_r;
    rsa_word_t   t_r;
    logic [7:0]  bit_idx;

    rsa256_mod_prod mod_prod_i (
        .avm_clk  (avm_clk),
        .avm_rst  (avm_rst),
        .start    (prep_start),
        .a        (job.base),
        .n        (job.modulus),
        .result   (prep_res),
        .finished (prep_done)
    );

    // m is kept in the normal domain, t in the Montgomery domain.
    rsa256_mont mont_mul_i (
        .avm_clk  (avm_clk),
        .avm_rst  (avm_rst),
        .start    (mont_start),
        .a        (m_r),
        .b        (t_r),
        .n        (job.modulus),
        .result   (mul_res),
        .finished (mul_done)
    );

    rsa256_mont mont_sq_i (
        .avm_clk  (avm_clk),
        .avm_rst  (avm_rst),
        .start    (mont_start),
        .a        (t_r),
        .b        (t_r),
        .n        (job.modulus),
        .result   (sq_res),
        .finished (sq_done)
    );

    always_ff @(posedge avm_clk or posedge avm_rst) begin
        if (avm_rst) begin
            state      <= CORE_IDLE;
            prep_start <= 1'b0;
            mont_start <= 1'b0;
            bit_idx    <= '0;
            finished   <= 1'b0;
        end else begin
            prep_start <= 1'b0;
            mont_start <= 1'b0;
            finished   <= 1'b0;
            case (state)
                CORE_IDLE: begin
                    if (start) begin
                        prep_start <= 1'b1;
                        state      <= CORE_PREP;
                    end
                end
                CORE_PREP: begin
                    if (prep_done) begin
                        mont_start <= 1'b1;
                        bit_idx    <= '0;
                        state      <= CORE_LOOP;
                    end
                end
                CORE_LOOP: begin
                    // both multipliers share one latency, so the squaring unit paces the loop.
                    if (sq_done) begin
                        if (bit_idx == 8'd255) begin
                            state <= CORE_DONE;
                        end else begin
                            bit_idx    <= bit_idx + 8'd1;
                            mont_start <= 1'b1;
                        end
                    end
                end
                default: begin
                    finished <= 1'b1;
                    state    <= CORE_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge avm_clk) begin
        if (prep_done) begin
            t_r <= prep_res;
            m_r <= 256'd1;
        end else begin
            if (sq_done) begin
                t_r <= sq_res;
            end
            if (mul_done && job.exp[bit_idx]) begin
                m_r <= mul_res;
            end
        end
    end

    assign result = m_r;

endmodule

//--- design/rsa256_wrapper.sv
`timescale 1ns/1ns

module rsa256_wrapper
    import rsa256_pkg::*;
(
    input  logic      avm_clk,
    input  logic      avm_rst,
    output avm_addr_t avm_address,
    output logic      avm_read,
    output logic      avm_write,
    input  avm_data_t avm_readdata,
    output avm_data_t avm_writedata,
    input  logic      avm_waitrequest
);

    wrap_state_t state_r;
    wrap_state_t state_nxt;
    byte_cnt_t   byte_cnt_r;
    byte_cnt_t   byte_cnt_nxt;
    logic        key_loaded_r;
    logic        key_loaded_nxt;
    avm_addr_t   address_r;
    avm_addr_t   address_nxt;
    logic        read_r;
    logic        read_nxt;
    logic        write_r;
    logic        write_nxt;
    logic        core_start_r;
    logic        core_start_nxt;
    logic        core_finished;
    rsa_word_t   core_result;
    rsa_job_t    job_r;
    rsa_word_t   dec_r;
    logic [7:0]  rx_byte;
    logic        bus_done;

    assign rx_byte       = avm_readdata[7:0];
    assign bus_done      = !avm_waitrequest;
    assign avm_address   = address_r;
    assign avm_read      = read_r;
    assign avm_write     = write_r;
    // only 248 bits of plaintext are sent, so byte 30 is the first one out.
    assign avm_writedata = {24'd0, dec_r[247:240]};

    rsa256_core core_i (
        .avm_clk  (avm_clk),
        .avm_rst  (avm_rst),
        .start    (core_start_r),
        .job      (job_r),
        .result   (core_result),
        .finished (core_finished)
    );

    always_comb begin
        state_nxt      = state_r;
        byte_cnt_nxt   = byte_cnt_r;
        key_loaded_nxt = key_loaded_r;
        address_nxt    = address_r;
        read_nxt       = read_r;
        write_nxt      = write_r;
        core_start_nxt = 1'b0;
        case (state_r)
            QUERY_RX: begin
                // without receive ready the status read is simply issued again.
                if (bus_done && avm_readdata[RX_OK_BIT]) begin
                    address_nxt = RX_BASE;
                    state_nxt   = key_loaded_r ? GET_DATA : GET_KEY;
                end
            end
            GET_KEY: begin
                if (bus_done) begin
                    address_nxt = STATUS_BASE;
                    state_nxt   = QUERY_RX;
                    if (byte_cnt_r == KEY_N_BYTES + KEY_D_BYTES - 7'd1) begin
                        byte_cnt_nxt   = '0;
                        key_loaded_nxt = 1'b1;
                    end else begin
                        byte_cnt_nxt = byte_cnt_r + 7'd1;
                    end
                end
            end
            GET_DATA: begin
                if (bus_done) begin
                    if (byte_cnt_r == BLOCK_BYTES - 7'd1) begin
                        byte_cnt_nxt   = '0;
                        read_nxt       = 1'b0;
                        core_start_nxt = 1'b1;
                        state_nxt      = WAIT_CALC;
                    end else begin
                        byte_cnt_nxt = byte_cnt_r + 7'd1;
                        address_nxt  = STATUS_BASE;
                        state_nxt    = QUERY_RX;
                    end
                end
            end
            WAIT_CALC: begin
                if (core_finished) begin
                    read_nxt    = 1'b1;
                    address_nxt = STATUS_BASE;
                    state_nxt   = QUERY_TX;
                end
            end
            QUERY_TX: begin
                if (bus_done && avm_readdata[TX_OK_BIT]) begin
                    read_nxt    = 1'b0;
                    write_nxt   = 1'b1;
                    address_nxt = TX_BASE;
                    state_nxt   = SEND_DATA;
                end
            end
            SEND_DATA: begin
                if (bus_done) begin
                    read_nxt    = 1'b1;
                    write_nxt   = 1'b0;
                    address_nxt = STATUS_BASE;
                    if (byte_cnt_r == OUT_BYTES - 7'd1) begin
                        byte_cnt_nxt = '0;
                        state_nxt    = QUERY_RX;
                    end else begin
                        byte_cnt_nxt = byte_cnt_r + 7'd1;
                        state_nxt    = QUERY_TX;
                    end
                end
            end
            default: begin
                state_nxt = QUERY_RX;
            end
        endcase
    end

    always_ff @(posedge avm_clk or posedge avm_rst) begin
        if (avm_rst) begin
            state_r      <= QUERY_RX;
            byte_cnt_r   <= '0;
            key_loaded_r <= 1'b0;
            address_r    <= STATUS_BASE;
            read_r       <= 1'b1;
            write_r      <= 1'b0;
            core_start_r <= 1'b0;
        end else begin
            state_r      <= state_nxt;
            byte_cnt_r   <= byte_cnt_nxt;
            key_loaded_r <= key_loaded_nxt;
            address_r    <= address_nxt;
            read_r       <= read_nxt;
            write_r      <= write_nxt;
            core_start_r <= core_start_nxt;
        end
    end

    // key and ciphertext arrive most significant byte first.
    always_ff @(posedge avm_clk) begin
        if (bus_done && state_r == GET_KEY) begin
            if (byte_cnt_r < KEY_N_BYTES) begin
                job_r.modulus <= {job_r.modulus[247:0], rx_byte};
            end else begin
                job_r.exp <= {job_r.exp[247:0], rx_byte};
            end
        end
        if (bus_done && state_r == GET_DATA) begin
            job_r.base <= {job_r.base[247:0], rx_byte};
        end
        if (state_r == WAIT_CALC && core_finished) begin
            dec_r <= core_result;
        end else if (bus_done && state_r == SEND_DATA) begin
            dec_r <= {dec_r[247:0], 8'h00};
        end
    end

endmodule

//--- sim/rsa256_wrapper_asserts.sv
`timescale 1ns/1ns

module rsa256_wrapper_asserts
    import rsa256_pkg::*;
(
    input logic      avm_clk,
    input logic      avm_rst,
    input avm_addr_t avm_address,
    input logic      avm_read,
    input logic      avm_write,
    input avm_data_t avm_writedata,
    input logic      avm_waitrequest
);

    int err_cnt = 0;

    // a stalled access keeps its address and strobes until the slave accepts it.
    hold_on_wait: assert property (@(posedge avm_clk) disable iff (avm_rst)
        (avm_read || avm_write) && avm_waitrequest |=>
            $stable(avm_address) && $stable(avm_read) && $stable(avm_write))
        else begin
            $error("address or strobe changed while waitrequest was high");
            err_cnt = err_cnt + 1;
        end

    one_strobe: assert property (@(posedge avm_clk) disable iff (avm_rst)
        !(avm_read && avm_write))
        else begin
            $error("read and write strobes are high together");
            err_cnt = err_cnt + 1;
        end

    write_target: assert property (@(posedge avm_clk) disable iff (avm_rst)
        avm_write |-> avm_address == TX_BASE)
        else begin
            $error("write to an address other than the transmit register");
            err_cnt = err_cnt + 1;
        end

    // a transmit write carries its byte in bits 7 to 0 and zeros above.
    write_data_upper: assert property (@(posedge avm_clk) disable iff (avm_rst)
        avm_write |-> avm_writedata[31:8] == 24'd0)
        else begin
            $error("transmit write has nonzero data above bit 7");
            err_cnt = err_cnt + 1;
        end

    read_target: assert property (@(posedge avm_clk) disable iff (avm_rst)
        avm_read |-> (avm_address == RX_BASE || avm_address == STATUS_BASE))
        else begin
            $error("read from an address other than receive or status");
            err_cnt = err_cnt + 1;
        end

    read_after_reset: assert property (@(posedge avm_clk)
        $fell(avm_rst) |-> avm_read && !avm_write && avm_address == STATUS_BASE)
        else begin
            $error("first cycle after reset is not a status read");
            err_cnt = err_cnt + 1;
        end

endmodule

bind rsa256_wrapper rsa256_wrapper_asserts bus_chk_i (
    .avm_clk         (avm_clk),
    .avm_rst         (avm_rst),
    .avm_address     (avm_address),
    .avm_read        (avm_read),
    .avm_write       (avm_write),
    .avm_writedata   (avm_writedata),
    .avm_waitrequest (avm_waitrequest)
);

//--- sim/rsa256_wrapper_tb.sv
`timescale 1ns/1ns

module rsa256_wrapper_tb
    import rsa256_pkg::*;
();

    localparam int CLK_PERIOD  = 8;
    localparam int SEED        = 71860;
    localparam int NUM_BLOCKS  = 4;
    localparam int WATCHDOG_NS = NUM_BLOCKS * 300000 * CLK_PERIOD;
    localparam int N_OUT       = int'(OUT_BYTES);
    localparam int N_WORD      = int'(BLOCK_BYTES);
    localparam int SETTLE      = 64;

    logic       avm_clk;
    logic       avm_rst         = 1'b1;
    avm_addr_t  avm_address;
    logic       avm_read;
    logic       avm_write;
    avm_data_t  avm_readdata    = '0;
    avm_data_t  avm_writedata;
    logic       avm_waitrequest = 1'b0;
    logic [7:0] rx_q[$];
    logic [7:0] tx_q[$];
    int         rx_gap          = 0;
    int         pass_cnt        = 0;
    int         fail_cnt        = 0;

    rsa256_wrapper rsa256_wrapper_i (
        .avm_clk         (avm_clk),
        .avm_rst         (avm_rst),
        .avm_address     (avm_address),
        .avm_read        (avm_read),
        .avm_write       (avm_write),
        .avm_readdata    (avm_readdata),
        .avm_writedata   (avm_writedata),
        .avm_waitrequest (avm_waitrequest)
    );

    initial begin
        avm_clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) avm_clk = ~avm_clk;
        end
    end

    // serial peripheral model, answering the access the wrapper presents in this cycle.
    always @(posedge avm_clk) begin
        #1;
        if (rx_gap > 0) begin
            rx_gap = rx_gap - 1;
        end
        avm_waitrequest = ($urandom % 10) < 3;
        avm_readdata    = '0;
        if (avm_read && avm_address == STATUS_BASE) begin
            avm_readdata[RX_OK_BIT] = (rx_q.size() != 0) && (rx_gap == 0);
            avm_readdata[TX_OK_BIT] = ($urandom % 2) == 0;
        end else if (avm_read && avm_address == RX_BASE && rx_q.size() != 0) begin
            avm_readdata[7:0] = rx_q[0];
            if (!avm_waitrequest) begin
                void'(rx_q.pop_front());
                rx_gap = $urandom % 4;
            end
        end
        if (avm_write && !avm_waitrequest && avm_address == TX_BASE) begin
            tx_q.push_back(avm_writedata[7:0]);
        end
    end

    task automatic apply_reset();
        #1;
        avm_rst = 1'b1;
        repeat (3) @(posedge avm_clk);
        #1;
        avm_rst = 1'b0;
        @(posedge avm_clk);
    endtask

    task automatic queue_word(input rsa_word_t w);
        int i;
        for (i = N_WORD - 1; i >= 0; i--) begin
            rx_q.push_back(w[i * 8 +: 8]);
        end
    endtask

    // plain square-and-multiply, wide enough that no product overflows.
    task automatic mod_exp(input rsa_word_t base, input rsa_word_t pow, input rsa_word_t n,
                           output rsa_word_t res);
        logic [511:0] acc;
        logic [511:0] sq;
        logic [511:0] n_w;
        int           i;
        n_w = {256'd0, n};
        acc = 512'd1;
        sq  = {256'd0, base} % n_w;
        for (i = 0; i < 256; i++) begin
            if (pow[i]) begin
                acc = (acc * sq) % n_w;
            end
            sq = (sq * sq) % n_w;
        end
        res = acc[255:0];
    endtask

    task automatic run_block(input logic send_key, input rsa_word_t n, input rsa_word_t d,
                             input rsa_word_t base, output int errs);
        rsa_word_t  expected;
        logic [7:0] exp_byte;
        int         bus_errs;
        int         k;
        errs     = 0;
        bus_errs = rsa256_wrapper_i.bus_chk_i.err_cnt;
        mod_exp(base, d, n, expected);
        tx_q.delete();
        if (send_key) begin
            queue_word(n);
            queue_word(d);
        end
        queue_word(base);
        while (tx_q.size() < N_OUT) begin
            @(posedge avm_clk);
        end
        // a quiet stretch after the last byte exposes any write that should not happen.
        repeat (SETTLE) @(posedge avm_clk);
        for (k = 0; k < N_OUT; k++) begin
            exp_byte = expected[(N_OUT - 1 - k) * 8 +: 8];
            assert (tx_q[k] === exp_byte) else begin
                $display("[FAIL] %0t ns tx_byte[%0d] expected %02h actual %02h",
                         $time, k, exp_byte, tx_q[k]);
                errs = errs + 1;
            end
        end
        assert (tx_q.size() == N_OUT) else begin
            $display("error: %0d bytes were transmitted for one block instead of %0d",
                     tx_q.size(), N_OUT);
            errs = errs + 1;
        end
        assert (rx_q.size() == 0) else begin
            $display("error: %0d received bytes were never read", rx_q.size());
            errs = errs + 1;
        end
        assert (rsa256_wrapper_i.bus_chk_i.err_cnt == bus_errs) else begin
            $display("error: a bus protocol assertion failed during this block");
            errs = errs + 1;
        end
    endtask

    task automatic report_test(input string label, input int errs);
        if (errs == 0) begin
            pass_cnt++;
            $display("test %s: pass", label);
        end else begin
            fail_cnt++;
            $display("test %s: fail with %0d errors", label, errs);
        end
    endtask

    initial begin
        rsa_word_t n_a;
        rsa_word_t d_a;
        rsa_word_t n_b;
        int        errs;
        int        total;
        void'($urandom(SEED));
        n_a = 256'd3233;
        d_a = 256'd2753;
        n_b = 256'hC5A3_9E41_7B2D_13F7;
        apply_reset();

        run_block(1'b1, n_a, d_a, 256'd855, errs);
        report_test("decrypt one block", errs);

        run_block(1'b0, n_a, d_a, {224'd0, $urandom % 32'd3233}, errs);
        report_test("key retention", errs);

        // a new key is only accepted after a reset.
        apply_reset();
        run_block(1'b1, n_b, 256'd1, 256'h1F2E_3D4C_5B6A_7988, errs);
        total = errs;
        run_block(1'b0, n_b, 256'd1, 256'd0, errs);
        total = total + errs;
        report_test("exponent edge cases", total);

        $display("tests passed: %0d, tests failed: %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("error: watchdog expired before the tests finished");
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

//--- rsa256_wrapper.f
design/rsa256_pkg.sv
design/rsa256_mont.sv
design/rsa256_mod_prod.sv
design/rsa256_core.sv
design/rsa256_wrapper.sv
sim/rsa256_wrapper_asserts.sv
sim/rsa256_wrapper_tb.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -j 0 --top-module rsa256_wrapper_tb \
    -f rsa256_wrapper.f -o rsa256_sim &&
./obj_dir/rsa256_sim +verilator+error+limit+1000 | tee /dev/stderr |
    grep -q "ALL TESTS PASSED" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
